// ==== compile.f ====
hdl/lsu_pkg.sv
hdl/agu.sv
hdl/lsu_bus.sv
hdl/trap_csr.sv
hdl/data_ram.sv
hdl/lsu_top.sv
verif/lsu_tb.sv

// ==== hdl/agu.sv ====
`default_nettype none
`timescale 1ns/10ps

module agu (
  input  wire lsu_pkg::lsu_op_e      op,
  input  wire [lsu_pkg::XLEN-1:0]    pc,
  input  wire [lsu_pkg::XLEN-1:0]    base,
  input  wire [lsu_pkg::XLEN-1:0]    imm,
  output logic [lsu_pkg::XLEN-1:0]   address,
  output logic [lsu_pkg::LANES-1:0]  byteenable,
  output logic                       exception,
  output lsu_pkg::ecause_e           ecause,
  output logic [lsu_pkg::XLEN-1:0]   etval
);
  import lsu_pkg::*;

  logic pc_rel;
  logic imem_access;
  logic load_op;
  logic store_op;
  logic byte_op;
  logic half_op;
  logic word_op;

  assign pc_rel      = op inside {OP_AUIPC, OP_JAL, OP_BRANCH};
  assign imem_access = op inside {OP_JAL, OP_JALR, OP_BRANCH};
  assign load_op     = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
  assign store_op    = op inside {OP_SB, OP_SH, OP_SW};
  assign byte_op     = op inside {OP_LB, OP_LBU, OP_SB};
  assign half_op     = op inside {OP_LH, OP_LHU, OP_SH};
  assign word_op     = op inside {OP_LW, OP_SW};

  always_comb begin
    address = (pc_rel ? pc : base) + imm;
    if (op == OP_JALR) begin
      address[0] = 1'b0;  // jalr target drops the lowest bit.
    end

    byteenable = '0;
    exception  = 1'b0;
    if (imem_access || word_op) begin
      byteenable = '1;
      exception  = (address[1:0] != 2'b00);
    end else if (byte_op) begin
      byteenable = LANES'(1) << address[1:0];  // a single byte never faults.
    end else if (half_op) begin
      byteenable = address[1] ? 4'hC : 4'h3;
      exception  = address[0];
    end

    ecause = ECAUSE_NONE;
    etval  = '0;
    if (exception) begin
      etval = address;
      if (load_op) begin
        ecause = LOAD_ADDR_MISALIGN;
      end else if (store_op) begin
        ecause = STORE_ADDR_MISALIGN;
      end else begin
        ecause = INSTR_ADDR_MISALIGN;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

module data_ram #(
  parameter int RAM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        wb_cyc,
  input  wire                        wb_stb,
  input  wire                        wb_we,
  input  wire [lsu_pkg::XLEN-3:0]    wb_adr,
  input  wire [lsu_pkg::LANES-1:0]   wb_sel,
  input  wire [lsu_pkg::XLEN-1:0]    wb_dat_w,
  output logic [lsu_pkg::XLEN-1:0]   wb_dat_r,
  output logic                       wb_ack
);
  import lsu_pkg::*;

  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [XLEN-1:0]  mem [RAM_WORDS];
  logic [CNT_W-1:0] wait_cnt;
  logic [IDX_W-1:0] word_idx;

  assign word_idx = IDX_W'(wb_adr % RAM_WORDS);  // the address wraps onto the array.
  assign wb_ack   = wb_cyc && wb_stb && (wait_cnt == CNT_W'(WAIT_STATES));
  assign wb_dat_r = wb_ack ? mem[word_idx] : '0;

  // counts strobe cycles until the ack is due.
  always_ff @(posedge clk) begin
    if (rst || !(wb_cyc && wb_stb) || wb_ack) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ack && wb_we) begin
      for (int i = 0; i < LANES; i++) begin
        if (wb_sel[i]) begin
          mem[word_idx][8*i +: 8] <= wb_dat_w[8*i +: 8];
        end
      end
    end
  end

  // the master has to release the strobe right after each ack.
  a_ack_in_stb: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> wb_stb ##1 !wb_stb)
    else $error("ack outside of a single strobe.");

endmodule

`default_nettype wire

// ==== hdl/lsu_bus.sv ====
`default_nettype none
`timescale 1ns/10ps

module lsu_bus (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        req_valid,
  input  wire lsu_pkg::lsu_op_e      req_op,
  input  wire [lsu_pkg::XLEN-1:0]    req_wdata,
  input  wire [lsu_pkg::XLEN-1:0]    address,
  input  wire [lsu_pkg::LANES-1:0]   byteenable,
  input  wire                        exception,
  input  wire lsu_pkg::ecause_e      ecause,
  input  wire [lsu_pkg::XLEN-1:0]    etval,
  output logic                       req_ready,
  output logic                       rsp_valid,
  output logic [lsu_pkg::XLEN-1:0]   rsp_data,
  output logic                       rsp_exception,
  output lsu_pkg::ecause_e           rsp_ecause,
  output logic [lsu_pkg::XLEN-1:0]   rsp_etval,
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic                       wb_we,
  output logic [lsu_pkg::XLEN-3:0]   wb_adr,
  output logic [lsu_pkg::LANES-1:0]  wb_sel,
  output logic [lsu_pkg::XLEN-1:0]   wb_dat_w,
  input  wire [lsu_pkg::XLEN-1:0]    wb_dat_r,
  input  wire                        wb_ack,
  output logic                       trap_valid,
  output lsu_pkg::ecause_e           trap_cause,
  output logic [lsu_pkg::XLEN-1:0]   trap_value
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {IDLE, BUS, RESP} state_e;

  state_e          state;
  lsu_op_e         op_q;
  logic [1:0]      lane_q;
  logic            accept;
  logic            load_op;
  logic            store_op;
  logic [XLEN-1:0] store_data;
  logic [XLEN-1:0] lane_data;
  logic [XLEN-1:0] load_data;

  assign req_ready = (state == IDLE);
  assign accept    = req_valid && req_ready;
  assign load_op   = req_op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
  assign store_op  = req_op inside {OP_SB, OP_SH, OP_SW};

  assign trap_valid = rsp_valid && rsp_exception;
  assign trap_cause = rsp_ecause;
  assign trap_value = rsp_etval;

  // store data is copied into every lane, the select picks the live ones.
  always_comb begin
    case (req_op)
      OP_SB:   store_data = {LANES{req_wdata[7:0]}};
      OP_SH:   store_data = {2{req_wdata[15:0]}};
      default: store_data = req_wdata;
    endcase
  end

  always_comb begin
    lane_data = wb_dat_r >> {lane_q, 3'b000};
    case (op_q)
      OP_LB:   load_data = {{(XLEN-8){lane_data[7]}}, lane_data[7:0]};
      OP_LBU:  load_data = {{(XLEN-8){1'b0}}, lane_data[7:0]};
      OP_LH:   load_data = {{(XLEN-16){lane_data[15]}}, lane_data[15:0]};
      OP_LHU:  load_data = {{(XLEN-16){1'b0}}, lane_data[15:0]};
      OP_LW:   load_data = wb_dat_r;
      default: load_data = '0;  // stores return zero.
    endcase
  end

  // ####################################################################
  // request, bus cycle and response sequencing.
  // ####################################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= IDLE;
      rsp_valid     <= 1'b0;
      rsp_exception <= 1'b0;
      wb_cyc        <= 1'b0;
      wb_stb        <= 1'b0;
      wb_we         <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            rsp_exception <= exception;
            if ((load_op || store_op) && !exception) begin
              wb_cyc <= 1'b1;
              wb_stb <= 1'b1;
              wb_we  <= store_op;
              state  <= BUS;
            end else begin
              rsp_valid <= 1'b1;
              state     <= RESP;
            end
          end
        end
        BUS: begin
          if (wb_ack) begin
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            wb_we     <= 1'b0;
            rsp_valid <= 1'b1;
            state     <= RESP;
          end
        end
        default: state <= IDLE;  // one cycle of rest after the response.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q       <= req_op;
      lane_q     <= address[1:0];
      wb_adr     <= address[XLEN-1:2];
      wb_sel     <= byteenable;
      wb_dat_w   <= store_data;
      rsp_ecause <= ecause;
      rsp_etval  <= etval;
      rsp_data   <= (exception || load_op || store_op) ? '0 : address;
    end else if (state == BUS && wb_ack) begin
      rsp_data <= load_data;
    end
  end

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else $error("strobe outside of a bus cycle.");

  a_stb_stable: assert property (@(posedge clk) disable iff (rst)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_sel)
                          && $stable(wb_dat_w) && $stable(wb_we))
    else $error("bus request changed before ack.");

  a_rsp_pulse: assert property (@(posedge clk) disable iff (rst) rsp_valid |=> !rsp_valid)
    else $error("response held for two cycles.");

endmodule

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  localparam int XLEN = 32;
  localparam int LANES = XLEN / 8;  // byte lanes per word.

  // ####################################################################
  // operations accepted from the pipeline.
  // ####################################################################
  typedef enum logic [3:0] {
    OP_NONE   = 4'h0,
    OP_JAL    = 4'h1,
    OP_JALR   = 4'h2,
    OP_BRANCH = 4'h3,
    OP_AUIPC  = 4'h4,
    OP_LB     = 4'h5,
    OP_LBU    = 4'h6,
    OP_LH     = 4'h7,
    OP_LHU    = 4'h8,
    OP_LW     = 4'h9,
    OP_SB     = 4'hA,
    OP_SH     = 4'hB,
    OP_SW     = 4'hC
  } lsu_op_e;

  // RISC-V mcause codes for the misalign faults this slice can raise.
  typedef enum logic [3:0] {
    INSTR_ADDR_MISALIGN = 4'd0,
    LOAD_ADDR_MISALIGN  = 4'd4,
    STORE_ADDR_MISALIGN = 4'd6
  } ecause_e;

  // shares code 0 with the instruction misalign, the exception flag tells them apart.
  localparam ecause_e ECAUSE_NONE = INSTR_ADDR_MISALIGN;

  // trap register read port.
  localparam logic [1:0] CSR_CAUSE = 2'd0;
  localparam logic [1:0] CSR_TVAL  = 2'd1;
  localparam logic [1:0] CSR_COUNT = 2'd2;

endpackage

`default_nettype wire

// ==== hdl/lsu_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module lsu_top #(
  parameter int RAM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       req_valid,
  input  wire lsu_pkg::lsu_op_e     req_op,
  input  wire [lsu_pkg::XLEN-1:0]   req_pc,
  input  wire [lsu_pkg::XLEN-1:0]   req_base,
  input  wire [lsu_pkg::XLEN-1:0]   req_imm,
  input  wire [lsu_pkg::XLEN-1:0]   req_wdata,
  output logic                      req_ready,
  output logic                      rsp_valid,
  output logic [lsu_pkg::XLEN-1:0]  rsp_data,
  output logic                      rsp_exception,
  output lsu_pkg::ecause_e          rsp_ecause,
  output logic [lsu_pkg::XLEN-1:0]  rsp_etval,
  input  wire [1:0]                 csr_addr,
  output logic [lsu_pkg::XLEN-1:0]  csr_rdata
);
  import lsu_pkg::*;

  logic [XLEN-1:0]  agu_address;
  logic [LANES-1:0] agu_byteenable;
  logic             agu_exception;
  ecause_e          agu_ecause;
  logic [XLEN-1:0]  agu_etval;

  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [XLEN-3:0]  wb_adr;
  logic [LANES-1:0] wb_sel;
  logic [XLEN-1:0]  wb_dat_w;
  logic [XLEN-1:0]  wb_dat_r;
  logic             wb_ack;

  logic             trap_valid;
  ecause_e          trap_cause;
  logic [XLEN-1:0]  trap_value;

  agu u_agu (
    .op(req_op), .pc(req_pc), .base(req_base), .imm(req_imm),
    .address(agu_address), .byteenable(agu_byteenable), .exception(agu_exception),
    .ecause(agu_ecause), .etval(agu_etval)
  );

  lsu_bus u_lsu_bus (
    .clk(clk), .rst(rst), .req_valid(req_valid), .req_op(req_op), .req_wdata(req_wdata),
    .address(agu_address), .byteenable(agu_byteenable), .exception(agu_exception),
    .ecause(agu_ecause), .etval(agu_etval), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_exception(rsp_exception),
    .rsp_ecause(rsp_ecause), .rsp_etval(rsp_etval),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_sel(wb_sel),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .trap_valid(trap_valid), .trap_cause(trap_cause), .trap_value(trap_value)
  );

  trap_csr u_trap_csr (
    .clk(clk), .rst(rst), .trap_valid(trap_valid), .trap_cause(trap_cause),
    .trap_value(trap_value), .csr_addr(csr_addr), .csr_rdata(csr_rdata)
  );

  data_ram #(
    .RAM_WORDS(RAM_WORDS),
    .WAIT_STATES(WAIT_STATES)
  ) u_data_ram (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

endmodule

`default_nettype wire

// ==== hdl/trap_csr.sv ====
`default_nettype none
`timescale 1ns/10ps

module trap_csr (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       trap_valid,
  input  wire lsu_pkg::ecause_e     trap_cause,
  input  wire [lsu_pkg::XLEN-1:0]   trap_value,
  input  wire [1:0]                 csr_addr,
  output logic [lsu_pkg::XLEN-1:0]  csr_rdata
);
  import lsu_pkg::*;

  ecause_e         cause_q;
  logic [XLEN-1:0] tval_q;
  logic [XLEN-1:0] count_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cause_q <= ECAUSE_NONE;
      tval_q  <= '0;
      count_q <= '0;
    end else if (trap_valid) begin
      cause_q <= trap_cause;
      tval_q  <= trap_value;
      if (count_q != '1) begin
        count_q <= count_q + 1'b1;  // sticks at all ones.
      end
    end
  end

  always_comb begin
    case (csr_addr)
      CSR_CAUSE: csr_rdata = {{(XLEN-4){1'b0}}, cause_q};
      CSR_TVAL:  csr_rdata = tval_q;
      CSR_COUNT: csr_rdata = count_q;
      default:   csr_rdata = '0;
    endcase
  end

  a_count_monotonic: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> count_q >= $past(count_q))
    else $error("exception count went down.");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f compile.f -o lsu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

output=$(./obj_dir/lsu_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
  exit 0
fi
echo "Pass message not found."
exit 1

// ==== verif/lsu_patterns.txt ====
# op pc base imm wdata exp_data exp_exception exp_cause exp_etval, all hex.
# op codes 1 jal, 2 jalr, 3 branch, 4 auipc, 5 lb, 6 lbu, 7 lh, 8 lhu, 9 lw, a sb, b sh, c sw.
4 00001000 00000000 12345000 00000000 12346000 0 0 00000000
1 00002000 00000000 00000100 00000000 00002100 0 0 00000000
3 00003000 00000000 fffffff0 00000000 00002ff0 0 0 00000000
2 00000000 00004000 00000005 00000000 00004004 0 0 00000000
# misaligned control transfers
1 00001000 00000000 00000002 00000000 00000000 1 0 00001002
2 00000000 00005000 00000003 00000000 00000000 1 0 00005002
3 00006000 00000000 00000006 00000000 00000000 1 0 00006006
# stores and loads
c 00000000 00000100 00000000 11223344 00000000 0 0 00000000
9 00000000 00000100 00000000 00000000 11223344 0 0 00000000
a 00000000 00000100 00000001 000000aa 00000000 0 0 00000000
b 00000000 00000100 00000002 0000beef 00000000 0 0 00000000
9 00000000 00000100 00000000 00000000 beefaa44 0 0 00000000
5 00000000 00000100 00000001 00000000 ffffffaa 0 0 00000000
6 00000000 00000100 00000001 00000000 000000aa 0 0 00000000
7 00000000 00000100 00000002 00000000 ffffbeef 0 0 00000000
8 00000000 00000100 00000002 00000000 0000beef 0 0 00000000
5 00000000 00000100 00000000 00000000 00000044 0 0 00000000
7 00000000 00000100 00000000 00000000 ffffaa44 0 0 00000000
c 00000000 00000200 00000004 80017f02 00000000 0 0 00000000
5 00000000 00000200 00000007 00000000 ffffff80 0 0 00000000
6 00000000 00000204 00000002 00000000 00000001 0 0 00000000
7 00000000 00000204 00000000 00000000 00007f02 0 0 00000000
# misaligned loads and stores
7 00000000 00000100 00000001 00000000 00000000 1 4 00000101
9 00000000 00000100 00000002 00000000 00000000 1 4 00000102
8 00000000 00000100 00000003 00000000 00000000 1 4 00000103
b 00000000 00000100 00000003 ffffffff 00000000 1 6 00000103
c 00000000 00000100 00000001 00000000 00000000 1 6 00000101
9 00000000 00000100 00000000 00000000 beefaa44 0 0 00000000

// ==== verif/lsu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int RAM_WORDS    = 256;
  localparam int WAIT_STATES  = 1;
  localparam int MAX_PATTERNS = 64;

  logic            clk;
  logic            rst;
  logic            req_valid;
  lsu_op_e         req_op;
  logic [XLEN-1:0] req_pc;
  logic [XLEN-1:0] req_base;
  logic [XLEN-1:0] req_imm;
  logic [XLEN-1:0] req_wdata;
  logic            req_ready;
  logic            rsp_valid;
  logic [XLEN-1:0] rsp_data;
  logic            rsp_exception;
  ecause_e         rsp_ecause;
  logic [XLEN-1:0] rsp_etval;
  logic [1:0]      csr_addr;
  logic [XLEN-1:0] csr_rdata;

  // columns are op, pc, base, imm, wdata, data, exception, cause, etval.
  logic [XLEN-1:0] pat [MAX_PATTERNS][9];
  int              n_patterns = 0;
  int              cycles = 0;
  int              cycle_limit = 0;

  lsu_top #(
    .RAM_WORDS(RAM_WORDS),
    .WAIT_STATES(WAIT_STATES)
  ) u_lsu_top (
    .clk(clk), .rst(rst), .req_valid(req_valid), .req_op(req_op), .req_pc(req_pc),
    .req_base(req_base), .req_imm(req_imm), .req_wdata(req_wdata),
    .req_ready(req_ready), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
    .rsp_exception(rsp_exception), .rsp_ecause(rsp_ecause), .rsp_etval(rsp_etval),
    .csr_addr(csr_addr), .csr_rdata(csr_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Something failed");
      $fatal(1, "the run timed out after %0d cycles.", cycles);
    end
  end

  task automatic check_value(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %h, expected %h.", $time, what, actual, expected);
      $display("Something failed");
      $fatal(1, "a response did not match.");
    end
  endtask

  // ####################################################################
  // pattern file.
  // ####################################################################
  task automatic load_patterns();
    int    fd;
    int    fields;
    string line;
    fd = $fopen("verif/lsu_patterns.txt", "r");
    if (fd == 0) begin
      $display("Something failed");
      $fatal(1, "cannot open the pattern file verif/lsu_patterns.txt.");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or comment line.
      if (n_patterns == MAX_PATTERNS) begin
        $display("Something failed");
        $fatal(1, "the pattern file has more than %0d lines.", MAX_PATTERNS);
      end
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                       pat[n_patterns][0], pat[n_patterns][1], pat[n_patterns][2],
                       pat[n_patterns][3], pat[n_patterns][4], pat[n_patterns][5],
                       pat[n_patterns][6], pat[n_patterns][7], pat[n_patterns][8]);
      if (fields != 9) begin
        $display("Something failed");
        $fatal(1, "a pattern line has %0d fields instead of 9.", fields);
      end
      n_patterns++;
    end
    $fclose(fd);
    if (n_patterns == 0) begin
      $display("Something failed");
      $fatal(1, "the pattern file holds no operations.");
    end
  endtask

  // ####################################################################
  // one request and its response.
  // ####################################################################
  task automatic run_pattern(input int i);
    logic saw_cyc;
    while (!req_ready) begin
      @(posedge clk);
      #1;
    end
    req_valid = 1'b1;
    req_op    = lsu_op_e'(pat[i][0][3:0]);
    req_pc    = pat[i][1];
    req_base  = pat[i][2];
    req_imm   = pat[i][3];
    req_wdata = pat[i][4];
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    saw_cyc   = u_lsu_top.wb_cyc;
    while (!rsp_valid) begin
      @(posedge clk);
      #1;
      saw_cyc |= u_lsu_top.wb_cyc;
    end
    check_value(rsp_data, pat[i][5], $sformatf("pattern %0d rsp_data", i));
    check_value({31'b0, rsp_exception}, pat[i][6], $sformatf("pattern %0d rsp_exception", i));
    check_value({28'b0, rsp_ecause}, pat[i][7], $sformatf("pattern %0d rsp_ecause", i));
    check_value(rsp_etval, pat[i][8], $sformatf("pattern %0d rsp_etval", i));
    check_value({31'b0, req_ready}, '0,
                $sformatf("pattern %0d req_ready with the response", i));
    if (pat[i][6][0]) begin
      check_value({31'b0, saw_cyc}, '0, $sformatf("pattern %0d bus cycle on a fault", i));
    end
  endtask

  task automatic check_trap_regs();
    logic [XLEN-1:0] last_cause;
    logic [XLEN-1:0] last_tval;
    logic [XLEN-1:0] n_exc;
    last_cause = '0;
    last_tval  = '0;
    n_exc      = '0;
    for (int i = 0; i < n_patterns; i++) begin
      if (pat[i][6][0]) begin
        last_cause = pat[i][7];
        last_tval  = pat[i][8];
        n_exc      = n_exc + 1;
      end
    end
    @(posedge clk);  // the trap registers load on the edge after the response.
    #1;
    csr_addr = CSR_CAUSE;
    #1 check_value(csr_rdata, last_cause, "trap cause register");
    csr_addr = CSR_TVAL;
    #1 check_value(csr_rdata, last_tval, "trap value register");
    csr_addr = CSR_COUNT;
    #1 check_value(csr_rdata, n_exc, "exception count register");
    csr_addr = 2'd3;
    #1 check_value(csr_rdata, '0, "unused trap register address");
  endtask

  initial begin
    rst       = 1'b1;
    req_valid = 1'b0;
    req_op    = OP_NONE;
    req_pc    = '0;
    req_base  = '0;
    req_imm   = '0;
    req_wdata = '0;
    csr_addr  = CSR_CAUSE;
    load_patterns();
    cycle_limit = n_patterns * (WAIT_STATES + 4) + 100;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    for (int i = 0; i < n_patterns; i++) begin
      run_pattern(i);
    end
    check_trap_regs();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
